//--- verilog/cache_pkg.sv
package cache_pkg;

  // Sizes
  localparam int word_bits       = 32;  // CPU word width
  localparam int words_per_block = 4;
  localparam int offset_bits     = 2;   // Word select inside a block
  localparam int sets            = 16;
  localparam int index_bits      = 4;   // log2 of sets
  localparam int ways            = 4;
  localparam int age_bits        = 2;   // Enough to rank four ways
  localparam int byte_bits       = 2;   // Byte lanes below the word offset
  localparam int tag_bits        = word_bits - index_bits - offset_bits - byte_bits;
  localparam int block_bits      = word_bits * words_per_block;

  // Field positions in a CPU byte address
  localparam int offset_lsb = byte_bits;
  localparam int index_lsb  = byte_bits + offset_bits;  // Also the block alignment
  localparam int tag_lsb    = index_lsb + index_bits;

  typedef logic [word_bits-1:0]   word_t;
  typedef logic [block_bits-1:0]  block_t;   // Word 0 sits in the low bits
  typedef logic [tag_bits-1:0]    tag_t;
  typedef logic [index_bits-1:0]  index_t;
  typedef logic [offset_bits-1:0] offset_t;
  typedef logic [age_bits-1:0]    age_t;
  typedef logic [ways-1:0]        way_mask_t;  // One bit per way

  localparam age_t max_age = '1;  // Oldest way in a full set

  // One cache line as stored per way
  typedef struct packed {
    logic   valid;
    logic   dirty;
    age_t   age;
    tag_t   tag;
    block_t data;
  } line_t;

  // Read or write, for CPU and memory requests alike
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_e;

  // Controller states
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict,
    st_fill,
    st_update
  } state_e;

endpackage

//--- verilog/way_if.sv
`timescale 1ns/1ns

// Links the way storage, the lookup logic and the controller
interface way_if (
  input logic clk
);

  // From the controller
  logic                 rd_en;    // Register the indexed set next edge
  cache_pkg::index_t    index;    // Set for both read and write
  logic                 wr_en;    // Commit wr_line and new_age
  cache_pkg::way_mask_t wr_way;   // Way that takes wr_line

  // From the lookup
  cache_pkg::line_t                      wr_line;
  cache_pkg::age_t [cache_pkg::ways-1:0] new_age;  // Ages for every way of the set

  // From the array, registered candidates
  cache_pkg::line_t [cache_pkg::ways-1:0] lines;

  modport array (
    input  rd_en, index, wr_en, wr_way, wr_line, new_age,
    output lines
  );

  modport lookup (
    input  clk, lines,
    output wr_line, new_age
  );

  modport ctrl (
    output rd_en, index, wr_en, wr_way
  );

endinterface

//--- verilog/way_array.sv
`timescale 1ns/1ns

module way_array (
  input logic   clk,
  input logic   rst_n,
  way_if.array  way
);

  // Line storage without reset, valid bits kept apart with reset
  cache_pkg::line_t store [cache_pkg::ways][cache_pkg::sets];
  logic [cache_pkg::ways-1:0][cache_pkg::sets-1:0] valid_q;

  cache_pkg::line_t [cache_pkg::ways-1:0] rd_line;   // Set as it sits in storage
  cache_pkg::line_t [cache_pkg::ways-1:0] upd_line;  // Set after the pending write

  // Read view of the indexed set
  always_comb begin
    for (int w = 0; w < cache_pkg::ways; w++) begin
      rd_line[w]       = store[w][way.index];
      rd_line[w].valid = valid_q[w][way.index];  // Valid array is authoritative
    end
  end

  // What the candidates look like once the write lands
  always_comb begin
    for (int w = 0; w < cache_pkg::ways; w++) begin
      upd_line[w] = way.lines[w];
      if (way.wr_way[w]) begin
        upd_line[w] = way.wr_line;
      end
      upd_line[w].age = way.new_age[w];  // Every way of the set is re-aged
    end
  end

  // Valid bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;  // All ways invalid
    end else if (way.wr_en) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        if (way.wr_way[w]) begin
          valid_q[w][way.index] <= way.wr_line.valid;
        end
      end
    end
  end

  // Tag, dirty, age and data
  always_ff @(posedge clk) begin
    if (way.wr_en) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        if (way.wr_way[w]) begin
          store[w][way.index] <= way.wr_line;  // Selected way only
        end
        store[w][way.index].age <= way.new_age[w];  // Overrides the line age
      end
    end
  end

  // Registered candidates, refreshed on write so they track storage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      way.lines <= '0;
    end else if (way.wr_en) begin
      way.lines <= upd_line;
    end else if (way.rd_en) begin
      way.lines <= rd_line;  // Set read, one cycle after rd_en
    end
  end

  // Controller and lookup must agree on a single target way
  wr_way_onehot_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    way.wr_en |-> $onehot(way.wr_way)
  );

endmodule

//--- verilog/way_lookup.sv
`timescale 1ns/1ns

module way_lookup (
  way_if.lookup                 way,
  input  cache_pkg::tag_t       tag,
  input  cache_pkg::offset_t    offset,
  input  cache_pkg::op_e        rw,
  input  cache_pkg::word_t      wr_data,
  input  cache_pkg::block_t     fill_block,
  output logic                  hit,
  output cache_pkg::way_mask_t  hit_way,
  output cache_pkg::way_mask_t  victim_way,
  output logic                  victim_dirty,
  output cache_pkg::tag_t       victim_tag,
  output cache_pkg::block_t     victim_block,
  output cache_pkg::word_t      rd_word
);

  cache_pkg::line_t hit_line;     // Matching candidate or zero on a miss
  cache_pkg::line_t victim_line;
  cache_pkg::line_t base_line;    // Hit line or the fresh fill
  cache_pkg::line_t merged_line;
  int               victim_idx;
  logic             found_free;   // Some way is still invalid

  // Tag compare across the four registered candidates
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < cache_pkg::ways; w++) begin
      hit_way[w] = way.lines[w].valid && (way.lines[w].tag == tag);
      if (hit_way[w]) begin
        hit_line = way.lines[w];
      end
    end
  end

  assign hit = |hit_way;

  // Victim is the first free way or else the oldest
  always_comb begin
    victim_idx = 0;
    found_free = 1'b0;
    for (int w = 0; w < cache_pkg::ways; w++) begin
      if (!way.lines[w].valid && !found_free) begin
        victim_idx = w;
        found_free = 1'b1;
      end
    end
    if (!found_free) begin
      for (int w = 1; w < cache_pkg::ways; w++) begin
        if (way.lines[w].age > way.lines[victim_idx].age) victim_idx = w;  // Reaches max_age
      end
    end
    victim_way             = '0;
    victim_way[victim_idx] = 1'b1;
  end

  assign victim_line  = way.lines[victim_idx];
  assign victim_dirty = victim_line.valid && victim_line.dirty;  // Needs write-back
  assign victim_tag   = victim_line.tag;
  assign victim_block = victim_line.data;

  // Merge the write word into the base block
  always_comb begin
    if (hit) begin
      base_line = hit_line;
    end else begin
      base_line = '{valid: 1'b1, dirty: 1'b0, age: '0, tag: tag, data: fill_block};
    end
    merged_line     = base_line;  // Read hit keeps its dirty bit
    merged_line.age = '0;         // Ages travel on new_age
    if (rw == cache_pkg::op_write) begin
      merged_line.data[offset*cache_pkg::word_bits +: cache_pkg::word_bits] = wr_data;
      merged_line.dirty = 1'b1;
    end
  end

  assign way.wr_line = merged_line;
  assign rd_word     = merged_line.data[offset*cache_pkg::word_bits +: cache_pkg::word_bits];

  // LRU ages for the whole set
  always_comb begin
    for (int w = 0; w < cache_pkg::ways; w++) begin
      way.new_age[w] = way.lines[w].age;  // Invalid ways untouched
      if (hit) begin
        if (hit_way[w]) begin
          way.new_age[w] = '0;
        end else if (way.lines[w].valid && (way.lines[w].age < hit_line.age)) begin
          way.new_age[w] = way.lines[w].age + 1'b1;  // Only ways younger than the hit
        end
      end else begin
        if (victim_way[w]) begin
          way.new_age[w] = '0;  // Filled way is newest
        end else if (way.lines[w].valid && (way.lines[w].age != cache_pkg::max_age)) begin
          way.new_age[w] = way.lines[w].age + 1'b1;  // Saturates
        end
      end
    end
  end

  // A set never holds the same tag twice
  hit_way_onehot0_a: assert property (@(posedge way.clk) $onehot0(hit_way));

endmodule

//--- verilog/miss_fsm.sv
`timescale 1ns/1ns

module miss_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  way_if.ctrl                   way,
  // CPU request side
  input  logic                  cpu_req_enable,
  input  logic                  cpu_req_rw,
  input  cache_pkg::word_t      cpu_req_addr,
  input  cache_pkg::word_t      cpu_req_data,
  output logic                  cpu_req_ready,
  output logic                  cpu_res_ready,
  // Registered request towards the lookup
  output cache_pkg::tag_t       req_tag,
  output cache_pkg::offset_t    req_offset,
  output cache_pkg::op_e        req_rw,
  output cache_pkg::word_t      req_data,
  // Lookup results
  input  logic                  hit,
  input  cache_pkg::way_mask_t  hit_way,
  input  cache_pkg::way_mask_t  victim_way,
  input  logic                  victim_dirty,
  input  cache_pkg::tag_t       victim_tag,
  // Memory request side
  output logic                  mem_req_enable,
  output cache_pkg::op_e        mem_req_rw,
  output cache_pkg::word_t      mem_req_addr,
  input  logic                  mem_req_ready
);

  cache_pkg::state_e state, next_state;
  cache_pkg::index_t req_index;
  logic              cand_valid;  // Candidates hold the request set

  // Request register, loaded on accept
  always_ff @(posedge clk) begin
    if (cpu_req_enable && cpu_req_ready) begin
      req_tag    <= cpu_req_addr[cache_pkg::tag_lsb +: cache_pkg::tag_bits];
      req_index  <= cpu_req_addr[cache_pkg::index_lsb +: cache_pkg::index_bits];
      req_offset <= cpu_req_addr[cache_pkg::offset_lsb +: cache_pkg::offset_bits];
      req_rw     <= cache_pkg::op_e'(cpu_req_rw);
      req_data   <= cpu_req_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= cache_pkg::st_idle;
      cand_valid <= 1'b0;
    end else begin
      state      <= next_state;
      cand_valid <= way.rd_en;  // Array registers the set on the same edge
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      cache_pkg::st_idle: begin
        if (cpu_req_enable) next_state = cache_pkg::st_lookup;
      end
      cache_pkg::st_lookup: begin
        if (cand_valid) begin  // Decide on registered candidates only
          if (hit) begin
            next_state = cache_pkg::st_update;
          end else if (victim_dirty) begin
            next_state = cache_pkg::st_evict;
          end else begin
            next_state = cache_pkg::st_fill;
          end
        end
      end
      cache_pkg::st_evict: begin
        if (mem_req_ready) next_state = cache_pkg::st_fill;  // Write-back done
      end
      cache_pkg::st_fill: begin
        if (mem_req_ready) next_state = cache_pkg::st_update;
      end
      cache_pkg::st_update: next_state = cache_pkg::st_idle;  // After the response pulse
      default: next_state = cache_pkg::st_idle;
    endcase
  end

  // CPU handshake
  assign cpu_req_ready = (state == cache_pkg::st_idle);
  assign cpu_res_ready = (state == cache_pkg::st_update);

  // Array control
  assign way.index  = req_index;
  assign way.rd_en  = (state == cache_pkg::st_lookup) && !cand_valid;
  assign way.wr_en  = ((state == cache_pkg::st_lookup) && cand_valid && hit) ||
                      ((state == cache_pkg::st_fill) && mem_req_ready);  // Fill data present
  assign way.wr_way = (state == cache_pkg::st_fill) ? victim_way : hit_way;

  // Memory request, held steady by the frozen candidates
  assign mem_req_enable = (state == cache_pkg::st_evict) || (state == cache_pkg::st_fill);
  assign mem_req_rw     = (state == cache_pkg::st_evict) ? cache_pkg::op_write
                                                         : cache_pkg::op_read;
  assign mem_req_addr   = {((state == cache_pkg::st_evict) ? victim_tag : req_tag),
                           req_index, {cache_pkg::index_lsb{1'b0}}};  // Block aligned

  // Memory sees a stable request until it answers
  mem_req_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_req_enable && !mem_req_ready |=>
      mem_req_enable && $stable(mem_req_addr) && $stable(mem_req_rw)
  );

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ns

module cache_top (
  input  logic               clk,
  input  logic               rst_n,
  // CPU side
  input  logic               cpu_req_enable,
  input  logic               cpu_req_rw,       // 0 read, 1 write
  input  cache_pkg::word_t   cpu_req_addr,     // Byte address
  input  cache_pkg::word_t   cpu_req_data,
  output logic               cpu_req_ready,
  output logic               cpu_res_ready,
  output cache_pkg::word_t   cpu_res_data,
  // Main memory side
  output logic               mem_req_enable,
  output logic               mem_req_rw,
  output cache_pkg::word_t   mem_req_addr,     // Low 4 bits zero
  output cache_pkg::block_t  mem_req_data,
  input  logic               mem_req_ready,
  input  cache_pkg::block_t  mem_res_data
);

  cache_pkg::tag_t      req_tag;
  cache_pkg::offset_t   req_offset;
  cache_pkg::op_e       req_rw;
  cache_pkg::word_t     req_data;
  logic                 hit;
  cache_pkg::way_mask_t hit_way, victim_way;
  logic                 victim_dirty;
  cache_pkg::tag_t      victim_tag;
  cache_pkg::word_t     rd_word;
  cache_pkg::op_e       mem_op;

  way_if way_if_i (.clk(clk));

  way_array way_array_i (.clk(clk), .rst_n(rst_n), .way(way_if_i));

  way_lookup way_lookup_i (
    .way(way_if_i), .tag(req_tag), .offset(req_offset), .rw(req_rw),
    .wr_data(req_data), .fill_block(mem_res_data), .hit(hit), .hit_way(hit_way),
    .victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .victim_block(mem_req_data), .rd_word(rd_word)  // Victim block is the write-back data
  );

  miss_fsm miss_fsm_i (
    .clk(clk), .rst_n(rst_n), .way(way_if_i),
    .cpu_req_enable(cpu_req_enable), .cpu_req_rw(cpu_req_rw),
    .cpu_req_addr(cpu_req_addr), .cpu_req_data(cpu_req_data),
    .cpu_req_ready(cpu_req_ready), .cpu_res_ready(cpu_res_ready),
    .req_tag(req_tag), .req_offset(req_offset), .req_rw(req_rw), .req_data(req_data),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .mem_req_enable(mem_req_enable), .mem_req_rw(mem_op),
    .mem_req_addr(mem_req_addr), .mem_req_ready(mem_req_ready)
  );

  assign mem_req_rw = mem_op;  // 0 read, 1 write

  // Read word captured with the line write in st_lookup or st_fill
  always_ff @(posedge clk) begin
    if (way_if_i.wr_en) cpu_res_data <= rd_word;
  end

endmodule

//--- test/memory_model.sv
`timescale 1ns/1ns

// Main memory behind the cache, answers each block request after 0 to 5 idle cycles
module memory_model (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              mem_req_enable,
  input  logic              mem_req_rw,     // 1 is a write-back
  input  cache_pkg::word_t  mem_req_addr,
  input  cache_pkg::block_t mem_req_data,
  output logic              mem_req_ready,
  output cache_pkg::block_t mem_res_data
);

  cache_pkg::word_t  mem [1024];    // Word image, indexed by addr[11:2]
  cache_pkg::block_t blk;
  logic              busy = 1'b0;   // Request seen, wait running
  int                wait_left = 0;
  // Last transfers, read by the testbench
  int                rd_count = 0;
  int                wr_count = 0;
  int                seq = 0;       // Orders reads against writes
  int                rd_seq = 0;
  int                wr_seq = 0;
  cache_pkg::word_t  rd_addr, wr_addr;
  cache_pkg::block_t wr_data;

  function automatic cache_pkg::word_t start_word(input cache_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;  // Distinct word per address
  endfunction

  initial begin
    for (int k = 0; k < 1024; k++) begin
      mem[k] = start_word(32'(k) << 2);
    end
  end

  // Ready rises on a falling edge, the cache takes it on the next rising edge
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_req_ready <= 1'b0;
      mem_res_data  <= '0;
      busy = 1'b0;
    end else begin
      mem_req_ready <= 1'b0;  // One-cycle pulse
      if (mem_req_enable && !busy) begin
        busy      = 1'b1;
        wait_left = $urandom_range(5, 0);
      end
      if (busy && wait_left > 0) begin
        wait_left--;
      end else if (busy) begin
        busy = 1'b0;
        seq++;
        mem_req_ready <= 1'b1;
        for (int w = 0; w < 4; w++) begin
          if (mem_req_rw) mem[{mem_req_addr[11:4], 2'(w)}] = mem_req_data[w*32 +: 32];
          blk[w*32 +: 32] = mem[{mem_req_addr[11:4], 2'(w)}];
        end
        if (mem_req_rw) begin
          wr_count++;
          wr_seq  = seq;
          wr_addr = mem_req_addr;
          wr_data = mem_req_data;
        end else begin
          rd_count++;
          rd_seq  = seq;
          rd_addr = mem_req_addr;
        end
        mem_res_data <= blk;  // Held until the next transfer
      end
    end
  end

endmodule

//--- test/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

  localparam int n_random = 400;                  // Random CPU requests
  localparam int n_flush  = cache_pkg::sets * 4;  // Four fresh tags per set
  localparam int limit    = 40;                   // Cycle budget per request

  logic              clk, rst_n;
  logic              cpu_req_enable, cpu_req_rw, cpu_req_ready, cpu_res_ready;
  cache_pkg::word_t  cpu_req_addr, cpu_req_data, cpu_res_data, mem_req_addr;
  logic              mem_req_enable, mem_req_rw, mem_req_ready;
  cache_pkg::block_t mem_req_data, mem_res_data;

  // Reference model of memory contents and cache state
  cache_pkg::word_t img [1024];  // Expected value of every word
  cache_pkg::tag_t  m_tag   [cache_pkg::sets][cache_pkg::ways];
  logic             m_valid [cache_pkg::sets][cache_pkg::ways];
  logic             m_dirty [cache_pkg::sets][cache_pkg::ways];
  cache_pkg::age_t  m_age   [cache_pkg::sets][cache_pkg::ways];
  int               checks = 0;
  int               errors = 0;
  int               test_start = 0;  // Error count when the current test began

  cache_top cache_top_i (.*);
  memory_model memory_model_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #((n_random + n_flush) * limit * 10 + 200);
    $display("Watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  function automatic cache_pkg::word_t initial_word(input cache_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;  // Same rule as the memory fill
  endfunction

  // Current contents of a block as the model sees it
  function automatic cache_pkg::block_t block_of(input cache_pkg::tag_t tag,
                                                 input cache_pkg::index_t idx);
    cache_pkg::block_t b;
    for (int w = 0; w < 4; w++) begin
      b[w*32 +: 32] = img[{tag[3:0], idx, 2'(w)}];
    end
    return b;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // One CPU request, checked against the model, then the model steps
  task automatic cpu_access(input logic rw, input cache_pkg::word_t addr,
                            input cache_pkg::word_t data);
    cache_pkg::index_t idx;
    cache_pkg::tag_t   tag;
    cache_pkg::age_t   hit_age;
    cache_pkg::block_t victim_data;
    int                hit_w, vic, cycles, rd0, wr0;
    logic              evict, mem_seen;
    idx   = addr[7:4];
    tag   = addr[31:8];
    hit_w = -1;
    vic   = -1;
    for (int w = 0; w < 4; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) hit_w = w;
      if (!m_valid[idx][w] && vic < 0) vic = w;  // First free way
    end
    for (int w = 0; w < 4; w++) begin
      if (vic < 0 && m_age[idx][w] == cache_pkg::max_age) vic = w;  // Oldest of a full set
    end
    evict       = (hit_w < 0) && m_valid[idx][vic] && m_dirty[idx][vic];
    victim_data = block_of(m_tag[idx][vic], idx);
    rd0         = memory_model_i.rd_count;
    wr0         = memory_model_i.wr_count;
    mem_seen    = 1'b0;
    cycles      = 0;
    while (!cpu_req_ready && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    cpu_req_enable = 1'b1;
    cpu_req_rw     = rw;
    cpu_req_addr   = addr;
    cpu_req_data   = data;
    cycles         = 0;
    do begin
      @(negedge clk);
      cycles++;
      cpu_req_enable = 1'b0;  // Taken on the edge just passed
      mem_seen |= mem_req_enable;
    end while (!cpu_res_ready && cycles < limit);
    if (!cpu_res_ready) begin
      $display("No response to the request at %0h within %0d cycles", addr, limit);
      errors++;
      return;
    end
    if (rw) img[addr[11:2]] = data;
    check_value("cpu_res_data", cpu_res_data, img[addr[11:2]]);
    check_value("memory write count", memory_model_i.wr_count - wr0, evict);
    check_value("memory read count", memory_model_i.rd_count - rd0, hit_w < 0);
    if (hit_w >= 0) begin
      check_value("mem_req_enable on hit", mem_seen, 0);
      check_value("hit latency", cycles, 3);
      hit_age = m_age[idx][hit_w];
      for (int w = 0; w < 4; w++) begin
        if (m_valid[idx][w] && m_age[idx][w] < hit_age) m_age[idx][w]++;  // Younger ways age
      end
      m_age[idx][hit_w] = '0;
      m_dirty[idx][hit_w] |= rw;
    end else begin
      check_value("fill address", memory_model_i.rd_addr, {addr[31:4], 4'h0});
      if (evict) begin
        check_value("write-back address", memory_model_i.wr_addr, {m_tag[idx][vic], idx, 4'h0});
        check_value("write-back data", memory_model_i.wr_data, victim_data);
        check_value("write-back before fill", memory_model_i.wr_seq < memory_model_i.rd_seq, 1);
      end
      for (int w = 0; w < 4; w++) begin
        if (m_valid[idx][w] && m_age[idx][w] != cache_pkg::max_age) m_age[idx][w]++;
      end
      m_valid[idx][vic] = 1'b1;
      m_tag[idx][vic]   = tag;
      m_dirty[idx][vic] = rw;  // Write miss allocates dirty
      m_age[idx][vic]   = '0;
    end
  endtask

  initial begin
    cache_pkg::word_t addr;
    void'($urandom(32'hd1d4));
    rst_n          = 1'b0;
    cpu_req_enable = 1'b0;
    cpu_req_rw     = 1'b0;
    cpu_req_addr   = '0;
    cpu_req_data   = '0;
    for (int k = 0; k < 1024; k++) begin
      img[k] = initial_word(32'(k) << 2);
    end
    for (int s = 0; s < cache_pkg::sets; s++) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        m_tag[s][w]   = '0;
        m_valid[s][w] = 1'b0;  // Cache starts empty
        m_dirty[s][w] = 1'b0;
        m_age[s][w]   = '0;
      end
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cpu_res_ready", cpu_res_ready, 0);
    check_value("mem_req_enable", mem_req_enable, 0);
    check_value("cpu_req_ready", cpu_req_ready, 1);
    report_test("reset");
    for (int n = 0; n < n_random; n++) begin
      addr = {cache_pkg::tag_t'($urandom_range(7, 0)), 4'($urandom_range(15, 0)),
              2'($urandom_range(3, 0)), 2'b00};  // Eight tags compete for four ways
      cpu_access(1'($urandom_range(1, 0)), addr, $urandom);
    end
    report_test("random");
    for (int s = 0; s < cache_pkg::sets; s++) begin
      for (int ft = 8; ft < 12; ft++) begin
        cpu_access(1'b0, {cache_pkg::tag_t'(ft), cache_pkg::index_t'(s), 4'h0}, '0);
      end
    end
    for (int k = 0; k < 1024; k++) begin
      check_value($sformatf("memory word %0d", k), memory_model_i.mem[k], img[k]);
    end
    report_test("flush");
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/cache_pkg.sv
verilog/way_if.sv
verilog/way_array.sv
verilog/way_lookup.sv
verilog/miss_fsm.sv
verilog/cache_top.sv
test/memory_model.sv
test/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/cache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
